// File: source/bus_cmp_pkg.sv
// Widths and payload records shared by the bus compare design
// NUM_IDS is derived from ID_WIDTH, so every ID value owns one capture FIFO

package bus_cmp_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned ID_WIDTH   = 2;
    localparam int unsigned NUM_IDS    = 2 ** ID_WIDTH;
    localparam int unsigned ADDR_WIDTH = 16;
    localparam int unsigned LEN_WIDTH  = 4;
    localparam int unsigned DATA_WIDTH = 16;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [ID_WIDTH-1:0] id_t;

    // One bit per ID, used for AW flags and head-valid vectors
    typedef logic [NUM_IDS-1:0] id_flags_t;

    // Write address record, 22 bits
    typedef struct packed {
        id_t                   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
    } aw_beat_t;

    // Write data record, 17 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } w_beat_t;

endpackage

// File: source/chan_if.sv
// One valid/ready channel carrying a payload of type payload_t
// A beat moves on a rising edge with valid and ready both high

`timescale 1ns/1ns

interface chan_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;

    // Source side owns valid and payload
    modport src (
        output valid,
        output payload,
        input  ready
    );

    // Sink side only answers with ready
    modport dst (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// File: source/cmp_fifo.sv
// Circular buffer FIFO, not fall-through; head shows one cycle after push
// DEPTH of 2 or more, need not be a power of two; pop on empty is ignored

`timescale 1ns/1ns

module cmp_fifo #(
    parameter int unsigned DEPTH     = 4,
    parameter type         payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_valid_i,
    output logic     push_ready_o,
    input  payload_t push_data_i,
    output logic     head_valid_o,
    output payload_t head_data_o,
    input  logic     pop_i
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic push_en;
    logic pop_en;

    // --------------------------------------------------
    // Status and handshake
    // --------------------------------------------------
    assign push_ready_o = (count_q != CNT_W'(DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_data_o  = mem_q[rd_ptr_q];

    assign push_en = push_valid_i & push_ready_o;
    assign pop_en  = pop_i & head_valid_o;

    // --------------------------------------------------
    // Pointers and fill count
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                // Wrap by hand for depths that are not a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

// File: source/chan_tap.sv
// Two-way stream fork; downstream and capture each get every beat once
// Upstream ready rises only when both branches hold the beat

`timescale 1ns/1ns

module chan_tap (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic up_valid_i,
    output logic up_ready_o,
    output logic dn_valid_o,
    input  logic dn_ready_i,
    chan_if.src  cap
);

    // Branch already accepted the current beat
    logic taken_dn_q;
    logic taken_cap_q;

    logic dn_done;
    logic cap_done;
    logic retire;

    // --------------------------------------------------
    // Offer beat to branches not yet taken
    // --------------------------------------------------
    assign dn_valid_o = up_valid_i & ~taken_dn_q;
    assign cap.valid  = up_valid_i & ~taken_cap_q;

    // Branch holds the beat now or did so earlier
    assign dn_done  = taken_dn_q | dn_ready_i;
    assign cap_done = taken_cap_q | cap.ready;

    assign up_ready_o = dn_done & cap_done;
    assign retire     = up_valid_i & up_ready_o;

    // --------------------------------------------------
    // Taken bits
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            taken_dn_q  <= 1'b0;
            taken_cap_q <= 1'b0;
        end else if (retire) begin
            // Last branch accepted, start fresh for next beat
            taken_dn_q  <= 1'b0;
            taken_cap_q <= 1'b0;
        end else begin
            if (dn_valid_o && dn_ready_i) begin
                taken_dn_q <= 1'b1;
            end
            if (cap.valid && cap.ready) begin
                taken_cap_q <= 1'b1;
            end
        end
    end

endmodule

// File: source/id_sorted_capture.sv
// Sorts captured AW beats into one FIFO per transaction ID
// A full FIFO stalls only beats that carry its own ID

`timescale 1ns/1ns

module id_sorted_capture import bus_cmp_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    chan_if.dst                       cap,
    output id_flags_t                 head_valid_o,
    output aw_beat_t [NUM_IDS-1:0]    head_data_o,
    input  id_flags_t                 pop_i
);

    id_flags_t push_valid;
    id_flags_t push_ready;

    // --------------------------------------------------
    // Route by ID
    // --------------------------------------------------
    always_comb begin
        push_valid                  = '0;
        push_valid[cap.payload.id]  = cap.valid;
        cap.ready                   = push_ready[cap.payload.id];
    end

    // --------------------------------------------------
    // Per-ID FIFOs
    // --------------------------------------------------
    for (genvar id = 0; id < NUM_IDS; id++) begin : gen_id_fifo
        cmp_fifo #(
            .DEPTH     ( FIFO_DEPTH ),
            .payload_t ( aw_beat_t  )
        ) u_fifo (
            .clk_i        ( clk_i            ),
            .rst_n_i      ( rst_n_i          ),
            .push_valid_i ( push_valid[id]   ),
            .push_ready_o ( push_ready[id]   ),
            .push_data_i  ( cap.payload      ),
            .head_valid_o ( head_valid_o[id] ),
            .head_data_o  ( head_data_o[id]  ),
            .pop_i        ( pop_i[id]        )
        );
    end

endmodule

// File: source/pair_checker.sv
// Pairs FIFO heads of side A and side B and compares them
// Purely combinational; flags pulse in the cycle the pair is popped

`timescale 1ns/1ns

module pair_checker import bus_cmp_pkg::*; (
    input  id_flags_t              aw_a_valid_i,
    input  id_flags_t              aw_b_valid_i,
    input  aw_beat_t [NUM_IDS-1:0] aw_a_data_i,
    input  aw_beat_t [NUM_IDS-1:0] aw_b_data_i,
    input  logic                   w_a_valid_i,
    input  logic                   w_b_valid_i,
    input  w_beat_t                w_a_data_i,
    input  w_beat_t                w_b_data_i,
    output id_flags_t              aw_pop_o,
    output logic                   w_pop_o,
    output id_flags_t              aw_mismatch_o,
    output logic                   w_mismatch_o,
    output logic                   mismatch_o,
    output logic                   busy_o
);

    // --------------------------------------------------
    // AW pairs, one per ID
    // --------------------------------------------------
    // Pop as soon as both sides hold a head for this ID
    assign aw_pop_o = aw_a_valid_i & aw_b_valid_i;

    always_comb begin
        for (int id = 0; id < NUM_IDS; id++) begin
            aw_mismatch_o[id] = aw_pop_o[id] & (aw_a_data_i[id] != aw_b_data_i[id]);
        end
    end

    // --------------------------------------------------
    // W pair, strictly in order
    // --------------------------------------------------
    assign w_pop_o      = w_a_valid_i & w_b_valid_i;
    assign w_mismatch_o = w_pop_o & (w_a_data_i != w_b_data_i);

    // Summary outputs
    assign mismatch_o = (|aw_mismatch_o) | w_mismatch_o;
    // Any head valid means some capture FIFO still holds data
    assign busy_o     = (|aw_a_valid_i) | (|aw_b_valid_i) | w_a_valid_i | w_b_valid_i;

endmodule

// File: source/bus_cmp_top.sv
// Compares AW and W traffic of two bus copies, forwarding both unchanged
// Downstream payload is combinational; flags pulse once per compared pair

`timescale 1ns/1ns

module bus_cmp_top import bus_cmp_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Side A, AW upstream and downstream
    input  logic                  a_aw_valid_i,
    output logic                  a_aw_ready_o,
    input  id_t                   a_aw_id_i,
    input  logic [ADDR_WIDTH-1:0] a_aw_addr_i,
    input  logic [LEN_WIDTH-1:0]  a_aw_len_i,
    output logic                  a_aw_valid_o,
    input  logic                  a_aw_ready_i,
    output id_t                   a_aw_id_o,
    output logic [ADDR_WIDTH-1:0] a_aw_addr_o,
    output logic [LEN_WIDTH-1:0]  a_aw_len_o,
    // Side A, W
    input  logic                  a_w_valid_i,
    output logic                  a_w_ready_o,
    input  logic [DATA_WIDTH-1:0] a_w_data_i,
    input  logic                  a_w_last_i,
    output logic                  a_w_valid_o,
    input  logic                  a_w_ready_i,
    output logic [DATA_WIDTH-1:0] a_w_data_o,
    output logic                  a_w_last_o,
    // Side B, AW
    input  logic                  b_aw_valid_i,
    output logic                  b_aw_ready_o,
    input  id_t                   b_aw_id_i,
    input  logic [ADDR_WIDTH-1:0] b_aw_addr_i,
    input  logic [LEN_WIDTH-1:0]  b_aw_len_i,
    output logic                  b_aw_valid_o,
    input  logic                  b_aw_ready_i,
    output id_t                   b_aw_id_o,
    output logic [ADDR_WIDTH-1:0] b_aw_addr_o,
    output logic [LEN_WIDTH-1:0]  b_aw_len_o,
    // Side B, W
    input  logic                  b_w_valid_i,
    output logic                  b_w_ready_o,
    input  logic [DATA_WIDTH-1:0] b_w_data_i,
    input  logic                  b_w_last_i,
    output logic                  b_w_valid_o,
    input  logic                  b_w_ready_i,
    output logic [DATA_WIDTH-1:0] b_w_data_o,
    output logic                  b_w_last_o,
    // Compare results
    output id_flags_t             aw_mismatch_o,
    output logic                  w_mismatch_o,
    output logic                  mismatch_o,
    output logic                  busy_o
);

    chan_if #(.payload_t(aw_beat_t)) a_aw_cap ();
    chan_if #(.payload_t(aw_beat_t)) b_aw_cap ();
    chan_if #(.payload_t(w_beat_t))  a_w_cap ();
    chan_if #(.payload_t(w_beat_t))  b_w_cap ();

    id_flags_t              aw_a_head_valid, aw_b_head_valid, aw_pop;
    aw_beat_t [NUM_IDS-1:0] aw_a_head_data, aw_b_head_data;
    logic                   w_a_head_valid, w_b_head_valid, w_pop;
    w_beat_t                w_a_head_data, w_b_head_data;

    // --------------------------------------------------
    // Pass-through payload and capture packing
    // --------------------------------------------------
    assign a_aw_id_o   = a_aw_id_i;
    assign a_aw_addr_o = a_aw_addr_i;
    assign a_aw_len_o  = a_aw_len_i;
    assign a_w_data_o  = a_w_data_i;
    assign a_w_last_o  = a_w_last_i;
    assign b_aw_id_o   = b_aw_id_i;
    assign b_aw_addr_o = b_aw_addr_i;
    assign b_aw_len_o  = b_aw_len_i;
    assign b_w_data_o  = b_w_data_i;
    assign b_w_last_o  = b_w_last_i;

    assign a_aw_cap.payload = '{id: a_aw_id_i, addr: a_aw_addr_i, len: a_aw_len_i};
    assign b_aw_cap.payload = '{id: b_aw_id_i, addr: b_aw_addr_i, len: b_aw_len_i};
    assign a_w_cap.payload  = '{data: a_w_data_i, last: a_w_last_i};
    assign b_w_cap.payload  = '{data: b_w_data_i, last: b_w_last_i};

    // --------------------------------------------------
    // Forks
    // --------------------------------------------------
    chan_tap u_tap_aw_a (
        .clk_i, .rst_n_i,
        .up_valid_i ( a_aw_valid_i ), .up_ready_o ( a_aw_ready_o ),
        .dn_valid_o ( a_aw_valid_o ), .dn_ready_i ( a_aw_ready_i ),
        .cap        ( a_aw_cap     )
    );
    chan_tap u_tap_w_a (
        .clk_i, .rst_n_i,
        .up_valid_i ( a_w_valid_i ), .up_ready_o ( a_w_ready_o ),
        .dn_valid_o ( a_w_valid_o ), .dn_ready_i ( a_w_ready_i ),
        .cap        ( a_w_cap     )
    );
    chan_tap u_tap_aw_b (
        .clk_i, .rst_n_i,
        .up_valid_i ( b_aw_valid_i ), .up_ready_o ( b_aw_ready_o ),
        .dn_valid_o ( b_aw_valid_o ), .dn_ready_i ( b_aw_ready_i ),
        .cap        ( b_aw_cap     )
    );
    chan_tap u_tap_w_b (
        .clk_i, .rst_n_i,
        .up_valid_i ( b_w_valid_i ), .up_ready_o ( b_w_ready_o ),
        .dn_valid_o ( b_w_valid_o ), .dn_ready_i ( b_w_ready_i ),
        .cap        ( b_w_cap     )
    );

    // --------------------------------------------------
    // Capture
    // --------------------------------------------------
    id_sorted_capture #(.FIFO_DEPTH(FIFO_DEPTH)) u_cap_aw_a (
        .clk_i, .rst_n_i, .cap ( a_aw_cap ),
        .head_valid_o ( aw_a_head_valid ), .head_data_o ( aw_a_head_data ),
        .pop_i        ( aw_pop          )
    );
    id_sorted_capture #(.FIFO_DEPTH(FIFO_DEPTH)) u_cap_aw_b (
        .clk_i, .rst_n_i, .cap ( b_aw_cap ),
        .head_valid_o ( aw_b_head_valid ), .head_data_o ( aw_b_head_data ),
        .pop_i        ( aw_pop          )
    );

    // W stays in arrival order, single FIFO per side
    cmp_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(w_beat_t)) u_fifo_w_a (
        .clk_i, .rst_n_i,
        .push_valid_i ( a_w_cap.valid   ), .push_ready_o ( a_w_cap.ready ),
        .push_data_i  ( a_w_cap.payload ),
        .head_valid_o ( w_a_head_valid  ), .head_data_o  ( w_a_head_data ),
        .pop_i        ( w_pop           )
    );
    cmp_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(w_beat_t)) u_fifo_w_b (
        .clk_i, .rst_n_i,
        .push_valid_i ( b_w_cap.valid   ), .push_ready_o ( b_w_cap.ready ),
        .push_data_i  ( b_w_cap.payload ),
        .head_valid_o ( w_b_head_valid  ), .head_data_o  ( w_b_head_data ),
        .pop_i        ( w_pop           )
    );

    // Compare policy
    pair_checker u_checker (
        .aw_a_valid_i  ( aw_a_head_valid ), .aw_b_valid_i ( aw_b_head_valid ),
        .aw_a_data_i   ( aw_a_head_data  ), .aw_b_data_i  ( aw_b_head_data  ),
        .w_a_valid_i   ( w_a_head_valid  ), .w_b_valid_i  ( w_b_head_valid  ),
        .w_a_data_i    ( w_a_head_data   ), .w_b_data_i   ( w_b_head_data   ),
        .aw_pop_o      ( aw_pop          ), .w_pop_o      ( w_pop           ),
        .aw_mismatch_o ( aw_mismatch_o   ), .w_mismatch_o ( w_mismatch_o    ),
        .mismatch_o    ( mismatch_o      ), .busy_o       ( busy_o          )
    );

endmodule

// File: bench/tb_clk_gen.sv
// Free-running testbench clock, starts low
// PERIOD in ns, should be even

`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int unsigned PERIOD = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk_o = ~clk_o;
    end

endmodule

// File: bench/bus_cmp_asserts.sv
// Protocol checks on the compare top level, attached with bind
// Downstream hold rule is checked on side A only

`timescale 1ns/1ns

module bus_cmp_asserts import bus_cmp_pkg::*; (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input id_flags_t             aw_mismatch_o,
    input logic                  w_mismatch_o,
    input logic                  mismatch_o,
    input logic                  busy_o,
    input logic                  a_aw_valid_o,
    input logic                  a_aw_ready_i,
    input id_t                   a_aw_id_o,
    input logic [ADDR_WIDTH-1:0] a_aw_addr_o,
    input logic [LEN_WIDTH-1:0]  a_aw_len_o
);

    // Summary flag is the OR of all flags
    a_mismatch_or: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mismatch_o == ((|aw_mismatch_o) | w_mismatch_o))
        else $error("mismatch_o differs from OR of flags");

    // Nothing captured right after reset
    a_idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !busy_o)
        else $error("busy_o high after reset release");

    // Downstream beat held until accepted
    a_dn_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (a_aw_valid_o && !a_aw_ready_i) |=>
        (a_aw_valid_o && $stable({a_aw_id_o, a_aw_addr_o, a_aw_len_o})))
        else $error("a_aw downstream beat dropped or changed");

    // A flag needs data in the capture FIFOs
    a_flag_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mismatch_o |-> busy_o)
        else $error("flag raised while busy_o low");

endmodule

bind bus_cmp_top bus_cmp_asserts u_asserts (.*);

// File: bench/bus_cmp_tb.sv
// Table driven testbench for the AW/W bus compare checker
// Side index 0 is side A, 1 is side B; downstream ready is pseudo random

`timescale 1ns/1ns

module bus_cmp_tb;
    import bus_cmp_pkg::*;

    typedef struct packed {
        logic [1:0]            mask;
        id_t                   id;
        logic [ADDR_WIDTH-1:0] a_addr;
        logic [ADDR_WIDTH-1:0] b_addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [DATA_WIDTH-1:0] a_data;
        logic [DATA_WIDTH-1:0] b_data;
        logic                  last;
        logic                  exp_aw;
        logic                  exp_w;
        logic                  pause;
    } row_t;

    localparam int NUM_ROWS    = 18;
    localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 200;

    // mask id a_addr b_addr len a_data b_data last exp_aw exp_w pause
    localparam row_t ROWS [NUM_ROWS] = '{
        '{2'b11, 2'd0, 16'h1000, 16'h1000, 4'd3, 16'h00aa, 16'h00aa, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b11, 2'd1, 16'h2000, 16'h2000, 4'd1, 16'h1111, 16'h1111, 1'b0, 1'b0, 1'b0, 1'b0},
        '{2'b11, 2'd3, 16'h3000, 16'h3004, 4'd2, 16'h2222, 16'h2222, 1'b1, 1'b1, 1'b0, 1'b0},
        '{2'b11, 2'd2, 16'h4000, 16'h4000, 4'd0, 16'h3333, 16'h3334, 1'b1, 1'b0, 1'b1, 1'b0},
        // Reordered IDs across sides
        '{2'b01, 2'd0, 16'h5000, 16'h0000, 4'd5, 16'h4444, 16'h0000, 1'b0, 1'b0, 1'b0, 1'b0},
        '{2'b01, 2'd1, 16'h5100, 16'h0000, 4'd6, 16'h5555, 16'h0000, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b10, 2'd1, 16'h0000, 16'h5100, 4'd6, 16'h0000, 16'h4444, 1'b0, 1'b0, 1'b0, 1'b0},
        '{2'b10, 2'd0, 16'h0000, 16'h5000, 4'd5, 16'h0000, 16'h5555, 1'b1, 1'b0, 1'b0, 1'b0},
        // Five beats on side A fill the ID 2 FIFO
        '{2'b01, 2'd2, 16'h6000, 16'h0000, 4'd1, 16'h7000, 16'h0000, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b01, 2'd2, 16'h6001, 16'h0000, 4'd1, 16'h7001, 16'h0000, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b01, 2'd2, 16'h6002, 16'h0000, 4'd1, 16'h7002, 16'h0000, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b01, 2'd2, 16'h6003, 16'h0000, 4'd1, 16'h7003, 16'h0000, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b01, 2'd2, 16'h6004, 16'h0000, 4'd1, 16'h7004, 16'h0000, 1'b1, 1'b0, 1'b0, 1'b1},
        '{2'b10, 2'd2, 16'h0000, 16'h6000, 4'd1, 16'h0000, 16'h7000, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b10, 2'd2, 16'h0000, 16'h6001, 4'd1, 16'h0000, 16'h7001, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b10, 2'd2, 16'h0000, 16'h6002, 4'd1, 16'h0000, 16'h7002, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b10, 2'd2, 16'h0000, 16'h6003, 4'd1, 16'h0000, 16'h7003, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'b10, 2'd2, 16'h0000, 16'h6004, 4'd1, 16'h0000, 16'h7004, 1'b1, 1'b0, 1'b0, 1'b0}
    };

    logic clk;
    logic rst_n;

    logic              aw_valid_d [2];
    aw_beat_t          aw_beat_d  [2];
    logic              w_valid_d  [2];
    w_beat_t           w_beat_d   [2];
    logic              aw_rdy [2];
    logic              w_rdy  [2];
    logic              aw_dn_rdy [2];
    logic              w_dn_rdy  [2];
    logic              aw_dn_valid [2];
    logic              w_dn_valid  [2];
    aw_beat_t [1:0]    aw_dn_beat;
    w_beat_t  [1:0]    w_dn_beat;
    id_flags_t         aw_mismatch;
    logic              w_mismatch;
    logic              mismatch;
    logic              busy;

    // Pending stimulus and expected downstream beats per side
    aw_beat_t aw_q [2][$];
    w_beat_t  w_q  [2][$];
    aw_beat_t exp_aw_dn [2][$];
    w_beat_t  exp_w_dn  [2][$];

    int          aw_flag_cnt [NUM_IDS];
    int          exp_aw_cnt  [NUM_IDS];
    int          w_flag_cnt;
    int          exp_w_cnt;
    int          cycles;
    int unsigned lcg_state;

    tb_clk_gen #(.PERIOD(40)) u_clk (.clk_o(clk));

    bus_cmp_top #(.FIFO_DEPTH(4)) u_dut (
        .clk_i         ( clk ),
        .rst_n_i       ( rst_n ),
        .a_aw_valid_i  ( aw_valid_d[0] ),       .a_aw_ready_o ( aw_rdy[0] ),
        .a_aw_id_i     ( aw_beat_d[0].id ),     .a_aw_addr_i  ( aw_beat_d[0].addr ),
        .a_aw_len_i    ( aw_beat_d[0].len ),
        .a_aw_valid_o  ( aw_dn_valid[0] ),      .a_aw_ready_i ( aw_dn_rdy[0] ),
        .a_aw_id_o     ( aw_dn_beat[0].id ),    .a_aw_addr_o  ( aw_dn_beat[0].addr ),
        .a_aw_len_o    ( aw_dn_beat[0].len ),
        .a_w_valid_i   ( w_valid_d[0] ),        .a_w_ready_o  ( w_rdy[0] ),
        .a_w_data_i    ( w_beat_d[0].data ),    .a_w_last_i   ( w_beat_d[0].last ),
        .a_w_valid_o   ( w_dn_valid[0] ),       .a_w_ready_i  ( w_dn_rdy[0] ),
        .a_w_data_o    ( w_dn_beat[0].data ),   .a_w_last_o   ( w_dn_beat[0].last ),
        .b_aw_valid_i  ( aw_valid_d[1] ),       .b_aw_ready_o ( aw_rdy[1] ),
        .b_aw_id_i     ( aw_beat_d[1].id ),     .b_aw_addr_i  ( aw_beat_d[1].addr ),
        .b_aw_len_i    ( aw_beat_d[1].len ),
        .b_aw_valid_o  ( aw_dn_valid[1] ),      .b_aw_ready_i ( aw_dn_rdy[1] ),
        .b_aw_id_o     ( aw_dn_beat[1].id ),    .b_aw_addr_o  ( aw_dn_beat[1].addr ),
        .b_aw_len_o    ( aw_dn_beat[1].len ),
        .b_w_valid_i   ( w_valid_d[1] ),        .b_w_ready_o  ( w_rdy[1] ),
        .b_w_data_i    ( w_beat_d[1].data ),    .b_w_last_i   ( w_beat_d[1].last ),
        .b_w_valid_o   ( w_dn_valid[1] ),       .b_w_ready_i  ( w_dn_rdy[1] ),
        .b_w_data_o    ( w_dn_beat[1].data ),   .b_w_last_o   ( w_dn_beat[1].last ),
        .aw_mismatch_o ( aw_mismatch ),         .w_mismatch_o ( w_mismatch ),
        .mismatch_o    ( mismatch ),            .busy_o       ( busy )
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int pending_beats();
        int n;
        n = 0;
        for (int s = 0; s < 2; s++) begin
            n += aw_q[s].size() + w_q[s].size();
            n += exp_aw_dn[s].size() + exp_w_dn[s].size();
        end
        return n;
    endfunction

    // Random downstream ready, changed just after each edge
    always @(posedge clk) begin
        logic [31:0] r;
        #2;
        r = lcg_next();
        aw_dn_rdy[0] = r[16];
        aw_dn_rdy[1] = r[17];
        w_dn_rdy[0]  = r[18];
        w_dn_rdy[1]  = r[19];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // --------------------------------------------------
    // Drivers and monitors per side
    // --------------------------------------------------
    for (genvar s = 0; s < 2; s++) begin : gen_side
        always begin
            wait (aw_q[s].size() != 0);
            @(posedge clk);
            #2;
            aw_valid_d[s] = 1'b1;
            aw_beat_d[s]  = aw_q[s][0];
            do @(negedge clk); while (!aw_rdy[s]);
            @(posedge clk);
            #2;
            void'(aw_q[s].pop_front());
            aw_valid_d[s] = 1'b0;
        end

        always begin
            wait (w_q[s].size() != 0);
            @(posedge clk);
            #2;
            w_valid_d[s] = 1'b1;
            w_beat_d[s]  = w_q[s][0];
            do @(negedge clk); while (!w_rdy[s]);
            @(posedge clk);
            #2;
            void'(w_q[s].pop_front());
            w_valid_d[s] = 1'b0;
        end

        // Mid-cycle sampling keeps clear of edge updates
        always @(negedge clk) begin
            if (rst_n && aw_dn_valid[s] && aw_dn_rdy[s]) begin
                if (exp_aw_dn[s].size() == 0) begin
                    $display("Unexpected AW beat downstream on side %0d", s);
                    $display("Finished with errors");
                    $fatal(1);
                end
                check_val(s ? "b_aw_o" : "a_aw_o", exp_aw_dn[s].pop_front(), aw_dn_beat[s]);
            end
            if (rst_n && w_dn_valid[s] && w_dn_rdy[s]) begin
                if (exp_w_dn[s].size() == 0) begin
                    $display("Unexpected W beat downstream on side %0d", s);
                    $display("Finished with errors");
                    $fatal(1);
                end
                check_val(s ? "b_w_o" : "a_w_o", exp_w_dn[s].pop_front(), w_dn_beat[s]);
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            for (int id = 0; id < NUM_IDS; id++) begin
                if (aw_mismatch[id]) begin
                    aw_flag_cnt[id]++;
                end
            end
            if (w_mismatch) begin
                w_flag_cnt++;
            end
            // Summary flag rises with any single flag
            check_val("mismatch_o", (aw_mismatch != '0) || w_mismatch, mismatch);
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        row_t     r;
        aw_beat_t ab;
        w_beat_t  wb;
        rst_n     = 1'b0;
        cycles    = 0;
        lcg_state = 32'd65;
        w_flag_cnt = 0;
        exp_w_cnt  = 0;
        for (int s = 0; s < 2; s++) begin
            aw_valid_d[s] = 1'b0;
            aw_beat_d[s]  = '0;
            w_valid_d[s]  = 1'b0;
            w_beat_d[s]   = '0;
            aw_dn_rdy[s]  = 1'b0;
            w_dn_rdy[s]   = 1'b0;
        end
        for (int id = 0; id < NUM_IDS; id++) begin
            aw_flag_cnt[id] = 0;
            exp_aw_cnt[id]  = 0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = ROWS[i];
            for (int s = 0; s < 2; s++) begin
                if (r.mask[s]) begin
                    ab.id   = r.id;
                    ab.addr = s ? r.b_addr : r.a_addr;
                    ab.len  = r.len;
                    wb.data = s ? r.b_data : r.a_data;
                    wb.last = r.last;
                    aw_q[s].push_back(ab);
                    exp_aw_dn[s].push_back(ab);
                    w_q[s].push_back(wb);
                    exp_w_dn[s].push_back(wb);
                end
            end
            exp_aw_cnt[r.id] += r.exp_aw;
            exp_w_cnt        += r.exp_w;
            if (r.pause) begin
                // Side B idle, so the fifth side A beat must stall
                while (aw_q[0].size() > 1) begin
                    @(negedge clk);
                end
                repeat (8) begin
                    @(negedge clk);
                    check_val("a_aw_ready_o", 32'd0, aw_rdy[0]);
                end
                check_val("a_aw_pending", 32'd1, aw_q[0].size());
                check_val("busy_o", 32'd1, busy);
            end
        end

        do @(negedge clk); while (pending_beats() != 0 || busy);

        for (int id = 0; id < NUM_IDS; id++) begin
            check_val($sformatf("aw_mismatch_o[%0d] pulses", id), exp_aw_cnt[id],
                      aw_flag_cnt[id]);
        end
        check_val("w_mismatch_o pulses", exp_w_cnt, w_flag_cnt);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: all.f
source/bus_cmp_pkg.sv
source/chan_if.sv
source/cmp_fifo.sv
source/chan_tap.sv
source/id_sorted_capture.sv
source/pair_checker.sv
source/bus_cmp_top.sv
bench/tb_clk_gen.sv
bench/bus_cmp_asserts.sv
bench/bus_cmp_tb.sv
